//--- source/stepper_pkg.sv
package stepper_pkg;

	// one byte, the base width for the command fields.
	parameter int BYTE_BITS = 8;

	// signed step count, msb is the direction.
	parameter int COUNT_BITS = BYTE_BITS;

	// pulse width in prescaler ticks.
	parameter int WIDTH_BITS = BYTE_BITS;

	// prescaler divisor, tick period is divisor plus one.
	parameter int DIV_BITS = 16;

	// sequencer states.
	// a step is one high phase followed by one low phase.
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0, // waiting for a trigger, done is high.
		ST_HIGH = 2'd1, // step_out high phase.
		ST_LOW  = 2'd2  // step_out low phase.
	} stepper_state_t;

endpackage : stepper_pkg

//--- source/tick_gen.sv
`timescale 1ns/10ps

// free running prescaler that paces the whole controller.
// the tick is a clock enable, one clk wide, every tick_div+1 cycles.
module tick_gen #(
	parameter int DIV_BITS = stepper_pkg::DIV_BITS
) (
	input  logic                clk,
	input  logic                reset,
	input  logic [DIV_BITS-1:0] tick_div,
	output logic                tick
);

	logic [DIV_BITS-1:0] div_cnt; // runs 0 .. tick_div.

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			tick    <= 1'b0; // no tick straight out of reset.
		end
		else begin
			// >= so that a smaller tick_div written at run time
			// wraps at once instead of running through the full range.
			if (div_cnt >= tick_div) begin
				div_cnt <= '0; // wrap.
				tick    <= 1'b1; // one cycle pulse on the wrap.
			end
			else begin
				div_cnt <= div_cnt + 1'b1; // count up.
				tick    <= 1'b0;
			end
		end
	end

endmodule : tick_gen

//--- source/stepper_fsm.sv
`timescale 1ns/10ps

// sequencer for the step pulses.
// moves only on prescaler ticks, the pulse generator does all the counting
// and reports back through cmd_null, phase_end and last_step.
module stepper_fsm (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       tick,
	input  logic                       trigger,
	input  logic                       abort,
	input  logic                       cmd_null,
	input  logic                       phase_end,
	input  logic                       last_step,
	output stepper_pkg::stepper_state_t state,
	output logic                       start
);

	import stepper_pkg::*;

	stepper_state_t next_state; // combinational next state.

	// accept a trigger only on a tick while idle, and only for a real command.
	// a null command just leaves the machine idle.
	assign start = tick && trigger && (state == ST_IDLE) && !cmd_null;

	always_comb begin
		next_state = state; // hold by default.
		case (state)
			ST_IDLE: begin
				if (start) begin
					next_state = ST_HIGH; // first step begins.
				end
			end
			ST_HIGH: begin
				if (tick) begin
					if (abort) begin
						next_state = ST_IDLE; // stop mid pulse.
					end
					else if (phase_end) begin
						next_state = ST_LOW; // high time is over.
					end
				end
			end
			ST_LOW: begin
				if (tick) begin
					if (abort) begin
						next_state = ST_IDLE; // stop between pulses.
					end
					else if (phase_end) begin
						// last low phase ends the sequence
						if (last_step) begin
							next_state = ST_IDLE;
						end
						else begin
							next_state = ST_HIGH; // next step.
						end
					end
				end
			end
			default: begin
				next_state = ST_IDLE; // unused encoding, recover.
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end
		else begin
			state <= next_state;
		end
	end

endmodule : stepper_fsm

//--- source/step_pulse_gen.sv
`timescale 1ns/10ps

// datapath of the controller.
// holds the latched command, the width timer and the step counter, and
// produces the step, dir and done outputs from the sequencer state.
module step_pulse_gen #(
	parameter int COUNT_BITS = stepper_pkg::COUNT_BITS,
	parameter int WIDTH_BITS = stepper_pkg::WIDTH_BITS
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       tick,
	input  logic                       start,
	input  stepper_pkg::stepper_state_t state,
	input  logic [COUNT_BITS-1:0]      num_steps,
	input  logic [WIDTH_BITS-1:0]      pulse_width,
	output logic                       cmd_null,
	output logic                       phase_end,
	output logic                       last_step,
	output logic                       step_out,
	output logic                       dir,
	output logic                       done
);

	import stepper_pkg::*;

	logic [COUNT_BITS-1:0] saved_steps; // latched signed count.
	logic [WIDTH_BITS-1:0] saved_width; // latched width in ticks.
	logic [COUNT_BITS:0]   ext_steps;   // sign extended count.
	logic [COUNT_BITS:0]   abs_steps;   // magnitude, one bit wider.
	logic [WIDTH_BITS-1:0] width_cnt;   // ticks into the current phase.
	logic [COUNT_BITS:0]   step_cnt;    // finished high phases.
	logic                  busy;        // a sequence is running.

	assign busy = (state != ST_IDLE);

	// the command is checked live at the inputs, before it is latched.
	assign cmd_null = (num_steps == '0) || (pulse_width == '0);

	// one extra bit so that the most negative count has a magnitude.
	assign ext_steps = {saved_steps[COUNT_BITS-1], saved_steps};

	always_comb begin
		abs_steps = ext_steps; // positive, use as is.
		if (saved_steps[COUNT_BITS-1]) begin
			abs_steps = (~ext_steps) + 1'b1; // two's complement negate.
		end
	end

	// phase lasts saved_width ticks, timer starts at one.
	assign phase_end = tick && busy && (width_cnt == saved_width);

	// compared at the end of a low phase, after the high phase counted.
	assign last_step = (step_cnt == abs_steps);

	// command latch.
	always_ff @(posedge clk) begin
		if (start) begin
			saved_steps <= num_steps;
			saved_width <= pulse_width;
		end
	end

	// width timer and step counter.
	always_ff @(posedge clk) begin
		if (reset) begin
			width_cnt <= WIDTH_BITS'(1);
			step_cnt  <= '0;
		end
		else if (start) begin
			width_cnt <= WIDTH_BITS'(1); // fresh sequence.
			step_cnt  <= '0;
		end
		else if (tick && busy) begin
			if (phase_end) begin
				width_cnt <= WIDTH_BITS'(1); // restart for the next phase.
				// a step is counted when its high half ends
				if (state == ST_HIGH) begin
					step_cnt <= step_cnt + 1'b1;
				end
			end
			else begin
				width_cnt <= width_cnt + 1'b1; // one more tick in this phase.
			end
		end
	end

	// registered outputs, one cycle behind the state.
	always_ff @(posedge clk) begin
		if (reset) begin
			step_out <= 1'b0;
			done     <= 1'b1; // idle after reset.
			dir      <= 1'b0;
		end
		else begin
			step_out <= (state == ST_HIGH);
			done     <= (state == ST_IDLE);
			if (start) begin
				dir <= num_steps[COUNT_BITS-1]; // sign of the new count.
			end
		end
	end

endmodule : step_pulse_gen

//--- source/stepper_top.sv
`timescale 1ns/10ps

// single axis stepper pulse controller.
// prescaler, sequencer and pulse datapath, wired together.
module stepper_top #(
	parameter int COUNT_BITS = stepper_pkg::COUNT_BITS,
	parameter int WIDTH_BITS = stepper_pkg::WIDTH_BITS,
	parameter int DIV_BITS   = stepper_pkg::DIV_BITS
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [DIV_BITS-1:0]   tick_div,
	input  logic                  trigger,
	input  logic                  abort,
	input  logic [COUNT_BITS-1:0] num_steps,
	input  logic [WIDTH_BITS-1:0] pulse_width,
	output logic                  step_out,
	output logic                  dir,
	output logic                  done
);

	import stepper_pkg::*;

	logic           tick;      // clock enable from the prescaler.
	logic           start;     // latch strobe to the datapath.
	logic           cmd_null;  // live command has nothing to do.
	logic           phase_end; // current phase is over.
	logic           last_step; // all steps sent.
	stepper_state_t state;     // sequencer state.

	tick_gen #(
		.DIV_BITS(DIV_BITS)
	) i_tick_gen (
		.clk     (clk),
		.reset   (reset),
		.tick_div(tick_div),
		.tick    (tick)
	);

	stepper_fsm i_fsm (
		.clk      (clk),
		.reset    (reset),
		.tick     (tick),
		.trigger  (trigger),
		.abort    (abort),
		.cmd_null (cmd_null),
		.phase_end(phase_end),
		.last_step(last_step),
		.state    (state),
		.start    (start)
	);

	step_pulse_gen #(
		.COUNT_BITS(COUNT_BITS),
		.WIDTH_BITS(WIDTH_BITS)
	) i_pulse_gen (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.start      (start),
		.state      (state),
		.num_steps  (num_steps),
		.pulse_width(pulse_width),
		.cmd_null   (cmd_null),
		.phase_end  (phase_end),
		.last_step  (last_step),
		.step_out   (step_out),
		.dir        (dir),
		.done       (done)
	);

endmodule : stepper_top

//--- dv/stepper_tb.sv
`timescale 1ns/10ps

// self checking testbench for the stepper pulse controller.
module stepper_tb;

	import stepper_pkg::*;

	localparam int SEED      = 88852;
	localparam int NUM_FIXED = 8;
	localparam int NUM_RAND  = 12;
	localparam int NUM_TESTS = NUM_FIXED + NUM_RAND;
	localparam int SLACK     = 50; // idle cycles allowed per test.

	logic                  clk;
	logic                  reset;
	logic [DIV_BITS-1:0]   tick_div;
	logic                  trigger;
	logic                  abort;
	logic [COUNT_BITS-1:0] num_steps;
	logic [WIDTH_BITS-1:0] pulse_width;
	logic                  step_out;
	logic                  dir;
	logic                  done;

	// kind 0 is a plain command, 1 retriggers while busy, 2 aborts.
	string name_tab [NUM_TESTS];
	int    n_tab    [NUM_TESTS];
	int    w_tab    [NUM_TESTS];
	int    d_tab    [NUM_TESTS];
	int    kind_tab [NUM_TESTS];

	int unsigned rng_state;
	int          cycle_cnt = 0;
	int          cycle_limit;
	int          test_errs;
	int          pass_cnt;
	int          fail_cnt;
	string       test_name;

	// monitor results are cleared whenever clear_seq moves.
	int                  clear_seq = 0;
	int                  seen_seq = 0;
	logic [COUNT_BITS:0] pulse_cnt;
	int                  busy_cnt;
	int                  hi_len;
	int                  hi_min;
	int                  hi_max;
	logic                step_prev;

	stepper_top #(
		.COUNT_BITS(COUNT_BITS),
		.WIDTH_BITS(WIDTH_BITS),
		.DIV_BITS  (DIV_BITS)
	) i_dut (
		.clk        (clk),
		.reset      (reset),
		.tick_div   (tick_div),
		.trigger    (trigger),
		.abort      (abort),
		.num_steps  (num_steps),
		.pulse_width(pulse_width),
		.step_out   (step_out),
		.dir        (dir),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period.
	end

	// the watchdog limit is set from the command table at time zero.
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT never finished a command", cycle_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

	// the monitor samples on the falling edge where the outputs are stable.
	always @(negedge clk) begin
		if (reset || (seen_seq != clear_seq)) begin
			seen_seq  = clear_seq;
			pulse_cnt = '0;
			busy_cnt  = 0;
			hi_len    = 0;
			hi_min    = 1 << 30;
			hi_max    = 0;
			step_prev = step_out;
		end
		else begin
			if (step_out && !step_prev) begin
				pulse_cnt = pulse_cnt + 1'b1; // new step pulse.
				hi_len    = 1;
			end
			else if (step_out) begin
				hi_len = hi_len + 1;
			end
			else if (step_prev) begin
				// pulse just ended
				if (hi_len < hi_min) begin
					hi_min = hi_len;
				end
				if (hi_len > hi_max) begin
					hi_max = hi_len;
				end
			end
			if (!done) begin
				busy_cnt = busy_cnt + 1; // one busy cycle.
			end
			step_prev = step_out;
		end
	end

	function automatic int unsigned lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 8; // low bits of an lcg are weak.
	endfunction

	// expected result of one command from the controller rules.
	function automatic void model_command(input int n, input int w, input int d,
		output logic [COUNT_BITS:0] pulses, output logic sign,
		output int high_cyc, output int busy_cyc);
		int mag;
		mag = (n < 0) ? -n : n;
		if ((mag == 0) || (w == 0)) begin
			pulses   = '0; // a null command does nothing.
			sign     = 1'b0;
			high_cyc = 0;
			busy_cyc = 0;
		end
		else begin
			pulses   = (COUNT_BITS + 1)'(mag);
			sign     = (n < 0);
			high_cyc = w * (d + 1);
			busy_cyc = 2 * mag * w * (d + 1);
		end
	endfunction

	function automatic void set_entry(input int idx, input string name, input int n,
		input int w, input int d, input int kind);
		name_tab[idx] = name;
		n_tab[idx]    = n;
		w_tab[idx]    = w;
		d_tab[idx]    = d;
		kind_tab[idx] = kind;
	endfunction

	task automatic fill_table();
		set_entry(0, "div0_pos", 3, 2, 0, 0);
		set_entry(1, "div2_neg", -4, 1, 2, 0);
		set_entry(2, "div3_pos", 2, 3, 3, 0);
		set_entry(3, "zero_count", 0, 3, 1, 0);
		set_entry(4, "zero_width", 5, 0, 1, 0);
		set_entry(5, "most_negative", -128, 1, 0, 0);
		set_entry(6, "retrigger", 5, 2, 1, 1);
		set_entry(7, "abort", 10, 3, 1, 2);
		for (int i = NUM_FIXED; i < NUM_TESTS; i++) begin
			n_tab[i]    = int'(lcg_next() % 32'd41) - 20; // -20 .. 20.
			w_tab[i]    = int'(lcg_next() % 32'd4) + 1;   // 1 .. 4.
			d_tab[i]    = int'(lcg_next() % 32'd4);       // 0 .. 3.
			kind_tab[i] = 0;
			name_tab[i] = $sformatf("random_%0d", i - NUM_FIXED);
		end
	endtask

	task automatic check_count(input string what, input logic [COUNT_BITS:0] exp_val,
		input logic [COUNT_BITS:0] act_val);
		if (act_val !== exp_val) begin
			$display("FAILED %s %s expected %0d actual %0d", test_name, what, exp_val, act_val);
			test_errs++;
		end
	endtask

	task automatic check_dir(input string what, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("FAILED %s %s expected %b actual %b", test_name, what, exp_val, act_val);
			test_errs++;
		end
	endtask

	task automatic check_level(input string what, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("FAILED %s %s expected %b actual %b", test_name, what, exp_val, act_val);
			test_errs++;
		end
	endtask

	task automatic check_cycles(input string what, input int exp_val, input int act_val);
		if (act_val != exp_val) begin
			$display("FAILED %s %s expected %0d actual %0d", test_name, what, exp_val, act_val);
			test_errs++;
		end
	endtask

	task automatic finish_test();
		if (test_errs == 0) begin
			pass_cnt++;
			$display("%s: ok", test_name);
		end
		else begin
			fail_cnt++;
			$display("%s: %0d mismatches", test_name, test_errs);
		end
	endtask

	task automatic run_command(input int idx);
		logic [COUNT_BITS:0] exp_pulses;
		logic                exp_dir;
		int                  exp_high;
		int                  exp_busy;
		int                  n;
		int                  w;
		int                  d;
		int                  hold;
		n         = n_tab[idx];
		w         = w_tab[idx];
		d         = d_tab[idx];
		test_name = name_tab[idx];
		test_errs = 0;
		model_command(n, w, d, exp_pulses, exp_dir, exp_high, exp_busy);
		@(posedge clk);
		num_steps   <= COUNT_BITS'(n);
		pulse_width <= WIDTH_BITS'(w);
		tick_div    <= DIV_BITS'(d);
		repeat (6) @(posedge clk); // let the new divisor wrap once.
		clear_seq = clear_seq + 1;
		trigger <= 1'b1; // held until a tick accepts it.
		hold = 0;
		while (done && (hold < 2 * d + 6)) begin
			@(negedge clk);
			hold = hold + 1;
		end
		if (done && (exp_pulses != 0)) begin
			$display("%s: the command was not accepted while idle", test_name);
			test_errs++;
		end
		@(posedge clk);
		trigger <= 1'b0;
		if (kind_tab[idx] == 1) begin
			repeat (4) @(posedge clk);
			num_steps <= COUNT_BITS'(n + 4); // must not be latched.
			trigger   <= 1'b1;
			repeat (3 * (d + 1) + 1) @(posedge clk);
			trigger   <= 1'b0;
		end
		else if (kind_tab[idx] == 2) begin
			while (pulse_cnt < 3) @(posedge clk);
			abort <= 1'b1; // spans at least one tick.
			repeat (d + 2) @(posedge clk);
			abort <= 1'b0;
		end
		@(negedge clk);
		while (!done) @(negedge clk);
		repeat (10) @(negedge clk);
		check_level("done", 1'b1, done);
		check_level("step_out", 1'b0, step_out);
		if (exp_pulses != 0) begin
			check_dir("dir", exp_dir, dir);
		end
		@(posedge clk); // monitor values are stable here.
		if (kind_tab[idx] == 2) begin
			if (pulse_cnt >= exp_pulses) begin
				$display("%s: %0d of %0d pulses sent despite the abort", test_name,
					pulse_cnt, exp_pulses);
				test_errs++;
			end
			if (busy_cnt >= exp_busy) begin
				$display("%s: the abort did not cut the sequence short", test_name);
				test_errs++;
			end
		end
		else begin
			check_count("pulses", exp_pulses, pulse_cnt);
			check_cycles("busy", exp_busy, busy_cnt);
			if (exp_pulses != 0) begin
				check_cycles("high_min", exp_high, hi_min);
				check_cycles("high_max", exp_high, hi_max);
			end
		end
		finish_test();
	endtask

	initial begin
		logic [COUNT_BITS:0] pulses;
		logic                sign;
		int                  high_cyc;
		int                  busy_cyc;
		reset       <= 1'b1;
		trigger     <= 1'b0;
		abort       <= 1'b0;
		num_steps   <= '0;
		pulse_width <= '0;
		tick_div    <= '0;
		rng_state   = SEED;
		pass_cnt    = 0;
		fail_cnt    = 0;
		fill_table();
		cycle_limit = SLACK * (NUM_TESTS + 1);
		for (int i = 0; i < NUM_TESTS; i++) begin
			model_command(n_tab[i], w_tab[i], d_tab[i], pulses, sign, high_cyc, busy_cyc);
			cycle_limit = cycle_limit + busy_cyc;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// state right after reset
		test_name = "reset";
		test_errs = 0;
		@(negedge clk);
		check_level("done", 1'b1, done);
		check_level("step_out", 1'b0, step_out);
		check_dir("dir", 1'b0, dir);
		finish_test();

		for (int i = 0; i < NUM_TESTS; i++) begin
			run_command(i);
		end
		$display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Testbench passed");
		end
		else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule : stepper_tb

//--- project.f
source/stepper_pkg.sv
source/tick_gen.sv
source/stepper_fsm.sv
source/step_pulse_gen.sv
source/stepper_top.sv
dv/stepper_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = stepper_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
